// ==== rtl/x86_arch_pkg.sv ====
package x86_arch_pkg;

	localparam int WORD_W    = 32;
	localparam int REG_IDX_W = 3;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// full EFLAGS image
	typedef logic [WORD_W-1:0] eflags_t;

	localparam int FLAG_CF    = 0;
	localparam int FLAG_RSVD1 = 1;  // always reads one on x86
	localparam int FLAG_PF    = 2;
	localparam int FLAG_AF    = 4;
	localparam int FLAG_ZF    = 6;
	localparam int FLAG_SF    = 7;
	localparam int FLAG_DF    = 10;
	localparam int FLAG_OF    = 11;

	localparam eflags_t FLAGS_RESET = eflags_t'(1) << FLAG_RSVD1;

	// same opcode order as the legacy alu mux
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

endpackage

// ==== rtl/exec_pkg.sv ====
package exec_pkg;
	import x86_arch_pkg::*;

	typedef struct packed {
		alu_op_e  op;
		reg_idx_t dst;
		reg_idx_t src;
	} issue_t;

	typedef struct packed {
		word_t   result;
		eflags_t flags;
		eflags_t flag_mask;  // bits this op writes
		logic    wr_en;      // result goes back to dst
	} alu_out_t;

	typedef struct packed {
		reg_idx_t idx;
		word_t    data;
	} rf_write_t;

	// writeback report
	typedef struct packed {
		reg_idx_t dst;
		word_t    result;
		logic     wr_en;
		alu_op_e  op;
	} wb_t;

endpackage

// ==== rtl/daa_adjust.sv ====
`timescale 1ns/100ps

module daa_adjust (
	input  logic [7:0] in,
	output logic [7:0] out,
	output logic [1:0] digit_carry
);

	logic [4:0] lo;  // {carry, digit}
	logic [4:0] hi;

	// one BCD digit cell
	function automatic logic [4:0] adjust_digit(
		input logic [3:0] d,
		input logic       c
	);
		logic fix;
		fix = (d > 4'd9) || ((d == 4'd9) && c);
		adjust_digit = {fix, d + (fix ? 4'd6 : 4'd0) + {3'b000, c}};
	endfunction

	assign lo = adjust_digit(in[3:0], 1'b0);  // low digit has no carry in
	assign hi = adjust_digit(in[7:4], lo[4]);

	assign out         = {hi[3:0], lo[3:0]};
	assign digit_carry = {hi[4], lo[4]};

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu
	import x86_arch_pkg::*;
	import exec_pkg::*;
(
	input  alu_op_e  op,
	input  word_t    a,
	input  word_t    b,
	output alu_out_t res
);

	// status flags written by arithmetic and logic ops
	localparam eflags_t STATUS_MASK = (eflags_t'(1) << FLAG_OF) | (eflags_t'(1) << FLAG_SF) |
		(eflags_t'(1) << FLAG_ZF) | (eflags_t'(1) << FLAG_AF) |
		(eflags_t'(1) << FLAG_PF) | (eflags_t'(1) << FLAG_CF);
	localparam eflags_t DF_MASK = eflags_t'(1) << FLAG_DF;

	logic [32:0] sum;
	logic [32:0] diff;  // bit 32 is the borrow
	logic [7:0]  daa_byte;
	logic [1:0]  daa_carry;
	word_t       r;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	daa_adjust u_daa_adjust (
		.in          (a[7:0]),
		.out         (daa_byte),
		.digit_carry (daa_carry)
	);

	always_comb begin
		case (op)
			OP_ADD:  r = sum[31:0];
			OP_OR:   r = a | b;
			OP_NOT:  r = ~a;
			OP_DAA:  r = {a[31:8], daa_byte};  // upper bytes pass through
			OP_AND:  r = a & b;
			OP_CMP:  r = diff[31:0];
			default: r = '0;                   // cld, std
		endcase

		res                = '0;
		res.result         = r;
		res.flags[FLAG_SF] = r[31];
		res.flags[FLAG_ZF] = (r == '0);
		res.flags[FLAG_PF] = ~^r[7:0];
		res.flag_mask      = STATUS_MASK;

		case (op)
			OP_ADD: begin
				res.flags[FLAG_CF] = sum[32];
				res.flags[FLAG_AF] = a[4] ^ b[4] ^ sum[4];  // carry into bit 4
				res.flags[FLAG_OF] = (a[31] == b[31]) && (sum[31] != a[31]);
				res.wr_en          = 1'b1;
			end
			OP_OR, OP_AND: begin
				res.wr_en = 1'b1;  // of, cf, af stay clear
			end
			OP_NOT: begin
				res.flag_mask = '0;
				res.wr_en     = 1'b1;
			end
			OP_DAA: begin
				res.flags[FLAG_SF] = 1'b0;  // bcd is unsigned
				res.flags[FLAG_ZF] = (daa_byte == 8'h00);
				res.flags[FLAG_AF] = |daa_carry;
				res.flags[FLAG_CF] = |daa_carry;
				res.wr_en          = 1'b1;
			end
			OP_CMP: begin
				res.flags[FLAG_CF] = diff[32];
				res.flags[FLAG_AF] = a[4] ^ b[4] ^ diff[4];
				res.flags[FLAG_OF] = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			OP_CLD: begin
				res.flags     = '0;
				res.flag_mask = DF_MASK;
			end
			OP_STD: begin
				res.flags          = '0;
				res.flags[FLAG_DF] = 1'b1;
				res.flag_mask      = DF_MASK;
			end
		endcase
	end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
	import x86_arch_pkg::*;
	import exec_pkg::*;
#(
	parameter int NUM_REGS = 8
) (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_idx_t  rd_a_idx,
	output word_t     rd_a_data,
	input  reg_idx_t  rd_b_idx,
	output word_t     rd_b_data,
	input  logic      wr_en,
	input  rf_write_t wr
);

	word_t regs [NUM_REGS];

	// async reads see a write from the next cycle on
	assign rd_a_data = regs[rd_a_idx];
	assign rd_b_data = regs[rd_b_idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr.idx] <= wr.data;
		end
	end

endmodule

// ==== rtl/rf_write_arb.sv ====
`timescale 1ns/100ps

module rf_write_arb
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      wb_req,
	input  rf_write_t wb,
	input  logic      load_valid,
	input  rf_write_t load,
	output logic      wr_en,
	output rf_write_t wr,
	output logic      load_busy
);

	typedef enum logic {
		IDLE,
		HELD
	} state_e;

	state_e    state;
	rf_write_t held;  // parked host load

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (load_valid && wb_req) state <= HELD;
				HELD: if (!wb_req) state <= IDLE;  // buffer drains this edge
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && load_valid && wb_req)
			held <= load;
	end

	// writeback always first
	always_comb begin
		wr_en = 1'b0;
		wr    = wb;
		if (wb_req) begin
			wr_en = 1'b1;
		end else if (state == HELD) begin
			wr_en = 1'b1;
			wr    = held;
		end else if (load_valid) begin
			wr_en = 1'b1;
			wr    = load;
		end
	end

	assign load_busy = (state == HELD);

endmodule

// ==== rtl/eflags_reg.sv ====
`timescale 1ns/100ps

module eflags_reg
	import x86_arch_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    update,
	input  eflags_t new_flags,
	input  eflags_t mask,
	output eflags_t eflags
);

	eflags_t next_flags;

	// unmasked bits hold, reserved bit 1 included
	assign next_flags = (eflags & ~mask) | (new_flags & mask);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			eflags <= FLAGS_RESET;
		end else if (update) begin
			eflags <= next_flags;
		end
	end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/100ps

module exec_core
	import x86_arch_pkg::*;
	import exec_pkg::*;
#(
	parameter int NUM_REGS = 8
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      issue_valid,
	input  issue_t    issue,
	input  logic      load_valid,
	input  rf_write_t load,
	output logic      load_busy,
	output logic      wb_valid,
	output wb_t       wb,
	output eflags_t   eflags
);

	word_t     op_a;
	word_t     op_b;
	alu_out_t  alu_res;
	logic      wb_req;
	rf_write_t wb_wr;
	logic      rf_wr_en;
	rf_write_t rf_wr;

	// dst doubles as first operand in x86 two-address form
	reg_file #(
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_a_idx  (issue.dst),
		.rd_a_data (op_a),
		.rd_b_idx  (issue.src),
		.rd_b_data (op_b),
		.wr_en     (rf_wr_en),
		.wr        (rf_wr)
	);

	alu u_alu (
		.op  (issue.op),
		.a   (op_a),
		.b   (op_b),
		.res (alu_res)
	);

	assign wb_req = issue_valid && alu_res.wr_en;
	assign wb_wr  = '{idx: issue.dst, data: alu_res.result};

	rf_write_arb u_rf_write_arb (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_req     (wb_req),
		.wb         (wb_wr),
		.load_valid (load_valid),
		.load       (load),
		.wr_en      (rf_wr_en),
		.wr         (rf_wr),
		.load_busy  (load_busy)
	);

	eflags_reg u_eflags_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.update    (issue_valid),
		.new_flags (alu_res.flags),
		.mask      (alu_res.flag_mask),
		.eflags    (eflags)
	);

	// report lags issue by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			wb <= '{dst: issue.dst, result: alu_res.result, wr_en: alu_res.wr_en, op: issue.op};
		end
	end

endmodule

// ==== testbench/exec_checker.sv ====
`timescale 1ns/100ps

module exec_checker
	import x86_arch_pkg::*;
	import exec_pkg::*;
#(
	parameter int NUM_REGS = 8
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      issue_valid,
	input  issue_t    issue,
	input  logic      load_valid,
	input  rf_write_t load,
	input  logic      load_busy,
	input  logic      wb_valid,
	input  wb_t       wb,
	input  eflags_t   eflags,
	output int        errors,
	output int        checks
);

	localparam eflags_t STATUS_BITS = (eflags_t'(1) << FLAG_CF) | (eflags_t'(1) << FLAG_PF) |
		(eflags_t'(1) << FLAG_AF) | (eflags_t'(1) << FLAG_ZF) |
		(eflags_t'(1) << FLAG_SF) | (eflags_t'(1) << FLAG_OF);

	typedef struct packed {
		word_t   result;
		logic    wr;
		eflags_t flags;  // full image after the op
	} ref_t;

	word_t     regs_m [NUM_REGS];
	eflags_t   flags_m;
	logic      held_m;     // mirror of the parked host load
	rf_write_t held_load;
	logic      exp_valid;
	wb_t       exp_wb;
	logic      live = 1'b0;
	ref_t      step;
	int        err_cnt = 0;
	int        check_cnt = 0;

	assign errors = err_cnt;
	assign checks = check_cnt;

	function automatic ref_t ref_exec(alu_op_e op, word_t a, word_t b, eflags_t f_in);
		ref_t        r;
		word_t       res;
		eflags_t     nf;
		eflags_t     mask;
		logic [32:0] sx;
		logic [3:0]  lo;
		logic [3:0]  hi;
		logic        c_lo;
		logic        c_hi;
		nf   = '0;
		mask = STATUS_BITS;
		r.wr = 1'b1;
		case (op)
			OP_ADD: begin
				res = a + b;
				sx  = {a[31], a} + {b[31], b};
				nf[FLAG_CF] = ({1'b0, a} + {1'b0, b}) >= 33'h1_0000_0000;
				nf[FLAG_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
				nf[FLAG_OF] = sx[32] != sx[31];
			end
			OP_OR:  res = a | b;
			OP_AND: res = a & b;
			OP_NOT: begin
				res  = ~a;
				mask = '0;
			end
			OP_DAA: begin
				lo   = a[3:0];
				c_lo = lo > 4'd9;
				if (c_lo)
					lo = lo + 4'd6;
				hi   = a[7:4];
				c_hi = (hi > 4'd9) || (hi == 4'd9 && c_lo);
				hi   = hi + (c_hi ? 4'd6 : 4'd0) + (c_lo ? 4'd1 : 4'd0);
				res  = {a[31:8], hi, lo};
				nf[FLAG_AF] = c_lo | c_hi;
				nf[FLAG_CF] = c_lo | c_hi;
			end
			OP_CMP: begin
				res  = a - b;
				sx   = {a[31], a} - {b[31], b};
				r.wr = 1'b0;
				nf[FLAG_CF] = a < b;
				nf[FLAG_AF] = a[3:0] < b[3:0];
				nf[FLAG_OF] = sx[32] != sx[31];
			end
			default: begin  // cld and std only touch df
				res  = '0;
				r.wr = 1'b0;
				mask = eflags_t'(1) << FLAG_DF;
				nf[FLAG_DF] = (op == OP_STD);
			end
		endcase
		if (mask == STATUS_BITS) begin
			nf[FLAG_SF] = (op == OP_DAA) ? 1'b0 : res[31];
			nf[FLAG_ZF] = (op == OP_DAA) ? (res[7:0] == 8'h00) : (res == '0);
			nf[FLAG_PF] = ~^res[7:0];
		end
		r.result = res;
		r.flags  = (f_in & ~mask) | (nf & mask);
		return r;
	endfunction

	task automatic report_mismatch(input string msg);
		err_cnt++;
		$display("FAILED t=%0t: %s", $time, msg);
	endtask

	// inputs are sampled on the rising edge, after the falling-edge drive
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_m[i] = '0;
			end
			flags_m   = FLAGS_RESET;
			held_m    = 1'b0;
			held_load = '0;
			exp_valid = 1'b0;
			exp_wb    = '0;
			live      = 1'b0;
		end else begin
			live      = 1'b1;
			step      = ref_exec(issue.op, regs_m[issue.dst], regs_m[issue.src], flags_m);
			exp_valid = issue_valid;
			if (issue_valid) begin
				exp_wb  = '{dst: issue.dst, result: step.result, wr_en: step.wr, op: issue.op};
				flags_m = step.flags;
			end
			if (issue_valid && step.wr) begin
				regs_m[issue.dst] = step.result;
				if (!held_m && load_valid) begin  // collision
					held_m    = 1'b1;
					held_load = load;
				end
			end else if (held_m) begin
				regs_m[held_load.idx] = held_load.data;
				held_m = 1'b0;
			end else if (load_valid) begin
				regs_m[load.idx] = load.data;
			end
		end
	end

	always @(negedge clk) begin
		if (live) begin
			check_cnt++;
			if (wb_valid !== exp_valid) begin
				report_mismatch($sformatf("wb_valid %b, expected %b", wb_valid, exp_valid));
			end else if (exp_valid && wb !== exp_wb) begin
				report_mismatch($sformatf(
					"report op %0d r%0d %h wr %b, expected op %0d r%0d %h wr %b",
					wb.op, wb.dst, wb.result, wb.wr_en,
					exp_wb.op, exp_wb.dst, exp_wb.result, exp_wb.wr_en));
			end
			if (eflags !== flags_m)
				report_mismatch($sformatf("eflags %h, expected %h", eflags, flags_m));
			if (load_busy !== held_m)
				report_mismatch($sformatf("load_busy %b, expected %b", load_busy, held_m));
		end
	end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/100ps

module tb_top
	import x86_arch_pkg::*;
	import exec_pkg::*;
();

	localparam int NUM_REGS        = 8;
	localparam int RESET_CYCLES    = 5;
	localparam int DIRECTED_CYCLES = 75;  // five directed tests with drain
	localparam int RAND_ISSUES     = 300;
	localparam int READBACK_CYCLES = 12;
	// a random issue takes two cycles at most
	localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + 2 * RAND_ISSUES +
		READBACK_CYCLES + 100;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        issue_valid;
	issue_t      issue;
	logic        load_valid;
	rf_write_t   load;
	logic        load_busy;
	logic        wb_valid;
	wb_t         wb;
	eflags_t     eflags;
	int          errors;
	int          checks;
	int          cycle_count = 0;
	int          test_num = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;
	int          errs_before = 0;
	reg_idx_t    prev_dst;
	reg_idx_t    rnd_dst;
	reg_idx_t    rnd_src;
	logic [7:0]  daa_bytes [5] = '{8'h9A, 8'h0F, 8'h99, 8'h45, 8'h00};

	always #2 clk = ~clk;

	exec_core #(.NUM_REGS(NUM_REGS)) dut (
		.clk (clk), .arst_n (arst_n),
		.issue_valid (issue_valid), .issue (issue),
		.load_valid (load_valid), .load (load), .load_busy (load_busy),
		.wb_valid (wb_valid), .wb (wb), .eflags (eflags)
	);

	exec_checker #(.NUM_REGS(NUM_REGS)) chk (
		.clk (clk), .arst_n (arst_n),
		.issue_valid (issue_valid), .issue (issue),
		.load_valid (load_valid), .load (load), .load_busy (load_busy),
		.wb_valid (wb_valid), .wb (wb), .eflags (eflags),
		.errors (errors), .checks (checks)
	);

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: stimulus still running after %0d cycles", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	task automatic issue_op(input alu_op_e op, input reg_idx_t dst, input reg_idx_t src);
		@(negedge clk);
		issue_valid = 1'b1;
		issue       = '{op: op, dst: dst, src: src};
		load_valid  = 1'b0;
	endtask

	task automatic load_reg(input reg_idx_t idx, input word_t data);
		@(negedge clk);
		issue_valid = 1'b0;
		load_valid  = 1'b0;
		while (load_busy) @(negedge clk);
		load_valid = 1'b1;
		load       = '{idx: idx, data: data};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			issue_valid = 1'b0;
			load_valid  = 1'b0;
		end
	endtask

	task automatic drive_random_load();
		if (!load_busy && $urandom_range(9, 0) < 4) begin
			load_valid = 1'b1;
			load       = '{idx: reg_idx_t'($urandom_range(7, 0)), data: $urandom};
		end else begin
			load_valid = 1'b0;
		end
	endtask

	task automatic finish_test(input string name);
		int new_errs;
		idle_cycles(2);
		@(posedge clk);  // last falling-edge compare is done
		test_num++;
		new_errs    = errors - errs_before;
		errs_before = errors;
		if (new_errs == 0) begin
			tests_ok++;
			$display("test %0d %s: ok", test_num, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d mismatches", test_num, name, new_errs);
		end
	endtask

	initial begin
		void'($urandom(69));
		arst_n      = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		load_valid  = 1'b0;
		load        = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		load_reg(3'd0, 32'h7FFF_FFFF);
		load_reg(3'd1, 32'h0000_0001);
		load_reg(3'd2, 32'hFFFF_FFFF);
		load_reg(3'd3, 32'h0000_0001);
		load_reg(3'd4, 32'h0000_000F);
		load_reg(3'd5, 32'h0000_0001);
		issue_op(OP_ADD, 3'd0, 3'd1);  // signed overflow
		issue_op(OP_ADD, 3'd2, 3'd3);  // carry out, zero
		issue_op(OP_ADD, 3'd4, 3'd5);  // nibble carry
		finish_test("reset_and_add");

		load_reg(3'd0, 32'hF0F0_1234);
		load_reg(3'd1, 32'h0FF0_00FF);
		load_reg(3'd5, 32'h8000_000F);
		load_reg(3'd6, 32'h8000_0001);
		issue_op(OP_ADD, 3'd5, 3'd6);  // sets of, cf and af
		issue_op(OP_OR, 3'd0, 3'd1);
		load_reg(3'd2, 32'hF0F0_1234);
		load_reg(3'd3, 32'h0FF0_00FF);
		load_reg(3'd5, 32'h8000_000F);
		issue_op(OP_ADD, 3'd5, 3'd6);
		issue_op(OP_AND, 3'd2, 3'd3);
		issue_op(OP_NOT, 3'd1, 3'd1);
		finish_test("logic_ops");

		load_reg(3'd0, 32'h0000_0005);
		load_reg(3'd1, 32'h0000_0007);
		load_reg(3'd2, 32'h8000_0000);
		load_reg(3'd3, 32'h0000_0001);
		load_reg(3'd4, 32'h0000_0000);
		issue_op(OP_CMP, 3'd0, 3'd1);
		issue_op(OP_CMP, 3'd2, 3'd3);
		issue_op(OP_ADD, 3'd0, 3'd4);  // r0 must still be 5
		finish_test("cmp_keeps_dst");

		foreach (daa_bytes[i]) begin
			load_reg(3'd7, {24'hABCDEF, daa_bytes[i]});
			issue_op(OP_DAA, 3'd7, 3'd7);
		end
		finish_test("daa_bytes");

		issue_op(OP_STD, 3'd0, 3'd0);
		issue_op(OP_ADD, 3'd0, 3'd1);
		issue_op(OP_CMP, 3'd2, 3'd3);
		issue_op(OP_CLD, 3'd0, 3'd0);
		issue_op(OP_ADD, 3'd0, 3'd1);
		issue_op(OP_OR, 3'd2, 3'd3);
		finish_test("direction_flag");

		prev_dst = '0;
		for (int i = 0; i < RAND_ISSUES; i++) begin
			@(negedge clk);
			rnd_dst = ($urandom_range(3, 0) == 0) ? prev_dst : reg_idx_t'($urandom_range(7, 0));
			rnd_src = ($urandom_range(1, 0) == 0) ? prev_dst : reg_idx_t'($urandom_range(7, 0));
			issue_valid = 1'b1;
			issue       = '{op: alu_op_e'($urandom_range(7, 0)), dst: rnd_dst, src: rnd_src};
			drive_random_load();
			prev_dst = rnd_dst;
			if ($urandom_range(3, 0) == 0) begin
				@(negedge clk);
				issue_valid = 1'b0;
				drive_random_load();
			end
		end
		idle_cycles(1);  // let a parked load drain
		for (int r = 0; r < NUM_REGS; r++) begin
			issue_op(OP_OR, reg_idx_t'(r), reg_idx_t'(r));  // read back every register
		end
		finish_test("random_mix");

		$display("summary: %0d tests ok, %0d with mismatches, %0d checks, %0d errors",
			tests_ok, tests_bad, checks, errors);
		if (tests_bad == 0 && errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/x86_arch_pkg.sv
rtl/exec_pkg.sv
rtl/daa_adjust.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/rf_write_arb.sv
rtl/eflags_reg.sv
rtl/exec_core.sv
testbench/exec_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with Verilator and run it, log in sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_top -f filelist.f
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
